// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_width_conv_fifo
RTL_TOP   ?= width_conv_fifo
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_$(TOP)
VFLAGS    ?= --timing
PASS_MSG  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(SIM_BIN)

sim: $(BUILD_DIR)/$(SIM_BIN)
	@out=$$(./$(BUILD_DIR)/$(SIM_BIN) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
src/fifo_geom_pkg.sv
src/fifo_status_pkg.sv
src/ram_port_if.sv
src/sdp_ram_bank.sv
src/asym_ram.sv
src/fifo_ptr_ctrl.sv
src/width_conv_fifo.sv
tests/tb_width_conv_fifo.sv

// ==== src/asym_ram.sv ====
module asym_ram import fifo_geom_pkg::*; (
   input logic   clk,
   ram_port_if.mem port
);

   // word part of the byte address goes to every bank
   logic [wr_addr_w-1:0] bank_r_addr;

   // byte select part, registered alongside the bank read
   logic [lane_sel_w-1:0] lane_sel;
   logic [lane_sel_w-1:0] lane_sel_q;

   // registered outputs of the four banks
   logic [rd_data_w-1:0] bank_r_data [lanes];

   assign bank_r_addr = port.r_addr[rd_addr_w-1 -: wr_addr_w];
   assign lane_sel = port.r_addr[lane_sel_w-1:0];

   // write is parallel across the lanes, read enable is shared
   for (genvar i = 0; i < lanes; i++) begin : g_bank
      sdp_ram_bank #(
         .data_w(rd_data_w),
         .addr_w(wr_addr_w)
      ) u_bank (
         .clk   (clk),
         .w_en  (port.w_en),
         .w_addr(port.w_addr),
         .w_data(port.w_data.byte_lane[i]),
         .r_en  (port.r_en),
         .r_addr(bank_r_addr),
         .r_data(bank_r_data[i])
      );
   end

   // lane select follows the bank read so the mux lines up
   // with the data registered in the same cycle
   always_ff @(posedge clk) begin
      if (port.r_en) begin
         lane_sel_q <= lane_sel;
      end
   end

   // output mux, holds the last byte while no read is issued
   assign port.r_data = bank_r_data[lane_sel_q];

endmodule

// ==== src/fifo_geom_pkg.sv ====
package fifo_geom_pkg;

   // producer side word
   localparam int wr_data_w = 32;

   // consumer side byte
   localparam int rd_data_w = 8;

   // one bank per byte of a word
   localparam int lanes = wr_data_w / rd_data_w;

   // 16 words of storage
   localparam int wr_addr_w = 4;

   // picks one bank on the read side
   localparam int lane_sel_w = $clog2(lanes);

   // byte address, word address on top of the lane select
   localparam int rd_addr_w = wr_addr_w + lane_sel_w;

   // one stored word, seen whole or as its byte lanes
   // lane 0 sits in bits 7:0 and leaves the FIFO first
   typedef union packed {
      logic [wr_data_w-1:0] word;
      logic [lanes-1:0][rd_data_w-1:0] byte_lane;
   } wide_word_t;

endpackage

// ==== src/fifo_ptr_ctrl.sv ====
module fifo_ptr_ctrl import fifo_geom_pkg::*, fifo_status_pkg::*; (
   input  logic         clk,
   input  logic         rst,
   input  logic         wr,
   input  wide_word_t   wr_data,
   input  logic         rd,
   ram_port_if.ctrl     port,
   output logic         rd_valid,
   output byte_count_t  count,
   output fifo_status_t status
);

   // largest count that still leaves room for a whole word
   localparam byte_count_t wr_limit = byte_count_t'(capacity_bytes - lanes);

   // word pointer on the write side, byte pointer on the read side
   logic [wr_addr_w-1:0] wr_ptr;
   logic [rd_addr_w-1:0] rd_ptr;

   logic wr_ok;
   logic rd_ok;
   byte_count_t wr_add;
   byte_count_t rd_sub;
   byte_count_t count_next;

   // both requests judged on the count before this cycle
   assign wr_ok = wr && (count <= wr_limit);
   assign rd_ok = rd && (count != '0);

   // a write adds one word of bytes, a read takes one byte
   assign wr_add = wr_ok ? byte_count_t'(lanes) : '0;
   assign rd_sub = rd_ok ? byte_count_t'(1) : '0;
   assign count_next = count + wr_add - rd_sub;

   // requests to the memory, only accepted ones
   assign port.w_en = wr_ok;
   assign port.w_addr = wr_ptr;
   assign port.w_data = wr_data;
   assign port.r_en = rd_ok;
   assign port.r_addr = rd_ptr;

   // pointers wrap naturally at their width
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // byte count and read strobe
   // rd_valid lines up with the registered bank output
   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
         rd_valid <= 1'b0;
      end else begin
         count <= count_next;
         rd_valid <= rd_ok;
      end
   end

   // flags from the next count, errors latch until reset
   always_ff @(posedge clk) begin
      if (rst) begin
         status.full <= 1'b0;
         status.empty <= 1'b1;
         status.overflow <= 1'b0;
         status.underflow <= 1'b0;
      end else begin
         status.full <= count_next > wr_limit;
         status.empty <= count_next == '0;
         // dropped write
         if (wr && !wr_ok) begin
            status.overflow <= 1'b1;
         end
         // dropped read, no strobe goes out
         if (rd && !rd_ok) begin
            status.underflow <= 1'b1;
         end
      end
   end

endmodule

// ==== src/fifo_status_pkg.sv ====
package fifo_status_pkg;

   // bytes the FIFO can hold
   localparam int capacity_bytes = 64;

   // enough bits for 0 up to a full FIFO
   localparam int count_w = $clog2(capacity_bytes + 1);

   typedef logic [count_w-1:0] byte_count_t;

   // full means no room for one more word, not only count == capacity
   // overflow and underflow are sticky until reset
   typedef struct packed {
      logic full;
      logic empty;
      logic overflow;
      logic underflow;
   } fifo_status_t;

endpackage

// ==== src/ram_port_if.sv ====
interface ram_port_if import fifo_geom_pkg::*; ();

   // write side, one whole word per enable
   logic w_en;
   logic [wr_addr_w-1:0] w_addr;
   wide_word_t w_data;

   // read side, one byte per enable
   logic r_en;
   logic [rd_addr_w-1:0] r_addr;
   logic [rd_data_w-1:0] r_data;

   // pointer controller issues both requests
   modport ctrl (
      output w_en,
      output w_addr,
      output w_data,
      output r_en,
      output r_addr,
      input  r_data
   );

   // memory executes every enable it sees
   modport mem (
      input  w_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface

// ==== src/sdp_ram_bank.sv ====
module sdp_ram_bank #(
   parameter int data_w = 8,
   parameter int addr_w = 4
) (
   input  logic              clk,
   input  logic              w_en,
   input  logic [addr_w-1:0] w_addr,
   input  logic [data_w-1:0] w_data,
   input  logic              r_en,
   input  logic [addr_w-1:0] r_addr,
   output logic [data_w-1:0] r_data
);

   localparam int depth = 2 ** addr_w;

   logic [data_w-1:0] mem [depth];

   // write committed at the edge
   always_ff @(posedge clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // registered read, output holds between enables
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

// ==== src/width_conv_fifo.sv ====
module width_conv_fifo import fifo_geom_pkg::*, fifo_status_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 wr,
   input  logic [wr_data_w-1:0] wr_data,
   input  logic                 rd,
   output logic                 rd_valid,
   output logic [rd_data_w-1:0] rd_data,
   output byte_count_t          count,
   output logic                 full,
   output logic                 empty,
   output logic                 overflow,
   output logic                 underflow
);

   wide_word_t wr_word;
   fifo_status_t status;

   // shared memory ports between controller and storage
   ram_port_if ram_port ();

   assign wr_word.word = wr_data;

   fifo_ptr_ctrl u_ctrl (
      .clk     (clk),
      .rst     (rst),
      .wr      (wr),
      .wr_data (wr_word),
      .rd      (rd),
      .port    (ram_port.ctrl),
      .rd_valid(rd_valid),
      .count   (count),
      .status  (status)
   );

   asym_ram u_ram (
      .clk (clk),
      .port(ram_port.mem)
   );

   // byte straight from the registered read path
   assign rd_data = ram_port.r_data;

   // status flattened for the plain ports
   assign full = status.full;
   assign empty = status.empty;
   assign overflow = status.overflow;
   assign underflow = status.underflow;

endmodule

// ==== tests/tb_width_conv_fifo.sv ====
module tb_width_conv_fifo import fifo_geom_pkg::*, fifo_status_pkg::*; ();

   typedef enum logic [1:0] {
      op_idle,
      op_write,
      op_read,
      op_both
   } op_t;

   // one table row, expected values come from the byte-queue model
   typedef struct packed {
      op_t                  op;
      wide_word_t           data;
      byte_count_t          exp_count;
      fifo_status_t         exp_status;
      logic                 exp_valid;
      logic [rd_data_w-1:0] exp_byte;
   } step_t;

   logic                 clk;
   logic                 rst;
   logic                 wr;
   logic [wr_data_w-1:0] wr_data;
   logic                 rd;
   logic                 rd_valid;
   logic [rd_data_w-1:0] rd_data;
   byte_count_t          count;
   logic                 full;
   logic                 empty;
   logic                 overflow;
   logic                 underflow;

   step_t                steps[$];
   logic [rd_data_w-1:0] model_q[$];
   logic                 model_overflow;
   logic                 model_underflow;
   logic [31:0]          rng_state;
   logic                 table_ready;

   width_conv_fifo UUT (
      .clk      (clk),
      .rst      (rst),
      .wr       (wr),
      .wr_data  (wr_data),
      .rd       (rd),
      .rd_valid (rd_valid),
      .rd_data  (rd_data),
      .count    (count),
      .full     (full),
      .empty    (empty),
      .overflow (overflow),
      .underflow(underflow)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic wide_word_t next_word();
      wide_word_t w;
      rng_state = xorshift32(rng_state);
      w.word = rng_state;
      return w;
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input logic [rd_data_w-1:0] got,
                             input logic [rd_data_w-1:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("[ERROR] %s: got 0x%02h expected 0x%02h", name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("[ERROR] %s: got 0x%01h expected 0x%01h", name, got, exp));
      end
   endtask

   task automatic check_count(input string name, input byte_count_t got,
                              input byte_count_t exp);
      if (got !== exp) begin
         abort_run($sformatf("[ERROR] %s: got 0x%02h expected 0x%02h", name, got, exp));
      end
   endtask

   task automatic check_status(input string name, input fifo_status_t got,
                               input fifo_status_t exp);
      if (got !== exp) begin
         abort_run($sformatf("[ERROR] %s: got 0x%01h expected 0x%01h", name, got, exp));
      end
   endtask

   // model judges both requests on the level before the cycle
   task automatic add_step(input op_t op, input wide_word_t data);
      step_t s;
      logic  do_wr;
      logic  do_rd;
      int    level;
      do_wr = (op == op_write) || (op == op_both);
      do_rd = (op == op_read) || (op == op_both);
      level = model_q.size();
      s.op = op;
      s.data = data;
      s.exp_valid = 1'b0;
      s.exp_byte = '0;
      if (do_rd) begin
         if (level >= 1) begin
            s.exp_valid = 1'b1;
            s.exp_byte = model_q.pop_front();
         end else begin
            model_underflow = 1'b1;
         end
      end
      if (do_wr) begin
         if (level <= capacity_bytes - lanes) begin
            // lane 0 leaves first
            for (int i = 0; i < lanes; i++) begin
               model_q.push_back(data.byte_lane[i]);
            end
         end else begin
            model_overflow = 1'b1;
         end
      end
      s.exp_count = byte_count_t'(model_q.size());
      s.exp_status.full = model_q.size() > capacity_bytes - lanes;
      s.exp_status.empty = model_q.size() == 0;
      s.exp_status.overflow = model_overflow;
      s.exp_status.underflow = model_underflow;
      steps.push_back(s);
   endtask

   task automatic build_table();
      wide_word_t sel;
      wide_word_t data;
      // one word out as four bytes, back-to-back reads
      add_step(op_write, next_word());
      add_step(op_idle, '0);
      repeat (4) add_step(op_read, '0);
      add_step(op_idle, '0);
      // fill to capacity, then one dropped write
      repeat (16) add_step(op_write, next_word());
      add_step(op_write, next_word());
      repeat (capacity_bytes) add_step(op_read, '0);
      // read while empty
      add_step(op_read, '0);
      add_step(op_idle, '0);
      // random mix, pointers wrap here
      add_step(op_write, next_word());
      repeat (48) begin
         sel = next_word();
         data = next_word();
         add_step(op_t'(sel.word[1:0]), data);
      end
      // drain, the last reads hit an empty FIFO
      repeat (capacity_bytes + 4) add_step(op_read, '0);
      // refill so the final reset has a full FIFO to clear
      repeat (16) add_step(op_write, next_word());
      add_step(op_idle, '0);
   endtask

   task automatic drive_step(input op_t op, input wide_word_t data);
      wr <= (op == op_write) || (op == op_both);
      rd <= (op == op_read) || (op == op_both);
      wr_data <= data.word;
   endtask

   task automatic apply_reset();
      fifo_status_t idle_status;
      idle_status = '{full: 1'b0, empty: 1'b1, overflow: 1'b0, underflow: 1'b0};
      @(posedge clk);
      rst <= 1'b1;
      wr <= 1'b0;
      rd <= 1'b0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_count("count", count, '0);
      check_status("status", {full, empty, overflow, underflow}, idle_status);
      check_flag("rd_valid", rd_valid, 1'b0);
      // model restarts with the DUT
      model_q.delete();
      model_overflow = 1'b0;
      model_underflow = 1'b0;
   endtask

   // row i is driven at one edge and its results checked after the next
   task automatic run_table();
      step_t s;
      for (int i = 0; i <= steps.size(); i++) begin
         @(posedge clk);
         if (i < steps.size()) begin
            drive_step(steps[i].op, steps[i].data);
         end else begin
            drive_step(op_idle, '0);
         end
         @(negedge clk);
         if (i > 0) begin
            s = steps[i-1];
            check_flag("rd_valid", rd_valid, s.exp_valid);
            if (s.exp_valid) begin
               check_byte("rd_data", rd_data, s.exp_byte);
            end
            check_count("count", count, s.exp_count);
            check_status("status", {full, empty, overflow, underflow}, s.exp_status);
         end
      end
   endtask

   // watchdog
   initial begin
      wait (table_ready);
      repeat (100 * steps.size() + 20) @(posedge clk);
      abort_run("timeout: the test did not finish in the expected number of cycles");
   end

   initial begin
      rst = 1'b1;
      wr = 1'b0;
      rd = 1'b0;
      wr_data = '0;
      table_ready = 1'b0;
      rng_state = 32'hdcb0_50c7;
      model_overflow = 1'b0;
      model_underflow = 1'b0;
      build_table();
      table_ready = 1'b1;
      apply_reset();
      run_table();
      // sticky errors clear only here
      apply_reset();
      $display("=== PASS ===");
      $finish;
   end

endmodule
